/* list.f */
source/rv_pkg.sv
source/pipe_control.sv
source/stage_if.sv
source/stage_id.sv
source/regfile.sv
source/dependency_unit.sv
source/stage_ex.sv
source/stage_mem.sv
source/riscv_core.sv
tests/tb_mem_model.sv
tests/tb_riscv_core.sv

/* tests/tb_riscv_core.sv */
module tb_riscv_core;

  timeunit 1ns;
  timeprecision 1ps;

  import rv_pkg::*;

  localparam addr_t pc_at_reset = 32'h0000_0000;

  logic  clk = 1'b0;
  logic  rst_n;
  addr_t imem_addr;
  logic  imem_valid;
  data_t imem_data;
  logic  dmem_valid;
  logic  dmem_we;
  addr_t dmem_addr;
  data_t dmem_wdata;
  logic  dmem_ready;
  data_t dmem_rdata;
  logic  halted;

  data_t prog [$];
  int    errors = 0;

  riscv_core #(.reset_pc(pc_at_reset)) dut_i (
    .clk(clk), .rst_n(rst_n),
    .imem_addr(imem_addr), .imem_valid(imem_valid), .imem_data(imem_data),
    .dmem_valid(dmem_valid), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata),
    .halted(halted)
  );

  tb_mem_model mem_i (
    .clk(clk), .rst_n(rst_n),
    .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_valid(dmem_valid), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata)
  );

  always #10 clk = ~clk;

  // Instruction encoders.
  function automatic data_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_t rd, reg_t rs1, reg_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic data_t enc_i(logic [2:0] f3, reg_t rd, reg_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic data_t enc_lw(reg_t rd, reg_t rs1, logic [11:0] imm);
    return {imm, rs1, F3_WORD, rd, OPC_LOAD};
  endfunction

  function automatic data_t enc_sw(reg_t rs2, reg_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
  endfunction

  function automatic data_t enc_b(logic [2:0] f3, reg_t rs1, reg_t rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic data_t enc_lui(reg_t rd, logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic data_t enc_jal(reg_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic data_t slt_ref(data_t x, data_t y);
    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
  endfunction

  function automatic data_t fill_value(int idx);
    logic [7:0] i;
    i = idx[7:0];
    return {16'hC0DE, i, ~i}; // Untouched words are easy to spot.
  endfunction

  task automatic report_failure(string what);
    errors++;
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_word(string name, data_t expected, data_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("[FAIL] %s: expected 0x%08h, actual 0x%08h",
                               name, expected, actual));
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("[FAIL] %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic check_mem(string name, addr_t addr, data_t expected);
    check_word($sformatf("%s @0x%03h", name, addr), expected, mem_i.dmem[addr[9:2]]);
  endtask

  task automatic load_memories();
    for (int i = 0; i < 256; i++) begin
      mem_i.imem[i] = (i < prog.size()) ? prog[i] : WFI_INSN;
      mem_i.dmem[i] = fill_value(i);
    end
    mem_i.write_count = 0;
  endtask

  task automatic check_reset_state(string name);
    check_flag({name, " halted"}, 1'b0, halted);
    check_flag({name, " dmem_valid"}, 1'b0, dmem_valid);
    check_flag({name, " imem_valid"}, 1'b1, imem_valid);
    check_word({name, " imem_addr"}, pc_at_reset, imem_addr);
  endtask

  task automatic apply_reset(string name);
    @(negedge clk);
    rst_n = 1'b0;
    load_memories();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      if (i == 5) check_reset_state({name, " in reset"});
    end
    rst_n = 1'b1;
    check_reset_state({name, " after reset"});
  endtask

  task automatic wait_halted(string name);
    int cycles;
    cycles = 0;
    while (!halted && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) report_failure($sformatf("The %s program did not halt within 2000 cycles.", name));
  endtask

  task automatic run_program(string name);
    apply_reset(name);
    wait_halted(name);
  endtask

  task automatic test_alu();
    data_t a, b, u;
    data_t expected [14];
    a = -5;
    b = 300;
    u = 32'h1234_5000;
    prog.delete();
    prog.push_back(enc_i(F3_ADD, 1, 0, -5));
    prog.push_back(enc_i(F3_ADD, 2, 0, 300));
    prog.push_back(enc_lui(3, 20'h12345));
    prog.push_back(enc_r(F7_BASE, F3_ADD, 4, 1, 2));
    prog.push_back(enc_r(F7_SUB, F3_ADD, 5, 1, 2));
    prog.push_back(enc_r(F7_BASE, F3_AND, 6, 1, 2));
    prog.push_back(enc_r(F7_BASE, F3_OR, 7, 1, 2));
    prog.push_back(enc_r(F7_BASE, F3_XOR, 8, 1, 2));
    prog.push_back(enc_r(F7_BASE, F3_SLT, 9, 1, 2));
    prog.push_back(enc_r(F7_BASE, F3_SLT, 10, 2, 1));
    prog.push_back(enc_i(F3_ADD, 11, 3, 12'h678));
    prog.push_back(enc_i(F3_AND, 12, 1, 12'h0F0));
    prog.push_back(enc_i(F3_OR, 13, 2, -256));
    prog.push_back(enc_i(F3_XOR, 14, 1, 12'h555));
    prog.push_back(enc_i(F3_SLT, 15, 1, -4));
    prog.push_back(enc_i(F3_SLT, 16, 2, 5));
    for (int k = 0; k < 14; k++) prog.push_back(enc_sw(3 + k, 0, 12'h100 + 4 * k));
    prog.push_back(WFI_INSN);
    expected = '{u, a + b, a - b, a & b, a | b, a ^ b, slt_ref(a, b), slt_ref(b, a),
                 u + 32'h678, a & 32'h0F0, b | 32'hFFFF_FF00, a ^ 32'h555,
                 slt_ref(a, -4), slt_ref(b, 5)};
    run_program("alu");
    for (int k = 0; k < 14; k++) check_mem("alu", 32'h100 + 4 * k, expected[k]);
  endtask

  task automatic test_hazards();
    data_t r1, r2, r3, r4, r5, r6, r7, r8;
    prog.delete();
    prog.push_back(enc_i(F3_ADD, 1, 0, 7));
    prog.push_back(enc_r(F7_BASE, F3_ADD, 2, 1, 1));
    prog.push_back(enc_r(F7_BASE, F3_ADD, 3, 2, 1));
    prog.push_back(enc_r(F7_SUB, F3_ADD, 4, 3, 2));
    prog.push_back(enc_sw(4, 0, 12'h180));
    prog.push_back(enc_lw(5, 0, 12'h180)); // Load followed by its use.
    prog.push_back(enc_i(F3_ADD, 6, 5, 1));
    prog.push_back(enc_r(F7_BASE, F3_ADD, 7, 6, 5));
    prog.push_back(enc_sw(6, 0, 12'h184));
    prog.push_back(enc_sw(7, 0, 12'h188));
    prog.push_back(enc_lw(8, 0, 12'h184));
    prog.push_back(enc_sw(8, 0, 12'h18C));
    prog.push_back(enc_i(F3_ADD, 9, 0, 12'h190));
    prog.push_back(enc_sw(7, 9, 0)); // Base register just written.
    prog.push_back(WFI_INSN);
    r1 = 7;
    r2 = r1 + r1;
    r3 = r2 + r1;
    r4 = r3 - r2;
    r5 = r4;
    r6 = r5 + 1;
    r7 = r6 + r5;
    r8 = r6;
    run_program("hazards");
    check_mem("hazards", 32'h180, r4);
    check_mem("hazards", 32'h184, r6);
    check_mem("hazards", 32'h188, r7);
    check_mem("hazards", 32'h18C, r8);
    check_mem("hazards", 32'h190, r7);
  endtask

  task automatic test_backpressure();
    prog.delete();
    for (int k = 0; k < 16; k++) begin
      prog.push_back(enc_i(F3_ADD, 1, 0, k * 37 + 5));
      prog.push_back(enc_sw(1, 0, 12'h200 + 4 * k));
    end
    for (int k = 0; k < 16; k++) begin
      prog.push_back(enc_lw(2, 0, 12'h200 + 4 * k));
      prog.push_back(enc_i(F3_ADD, 2, 2, k));
      prog.push_back(enc_sw(2, 0, 12'h280 + 4 * k));
    end
    prog.push_back(WFI_INSN);
    run_program("backpressure");
    for (int k = 0; k < 16; k++) begin
      check_mem("backpressure", 32'h200 + 4 * k, k * 37 + 5);
      check_mem("backpressure", 32'h280 + 4 * k, k * 37 + 5 + k);
    end
    check_mem("backpressure", 32'h240, fill_value(32'h240 >> 2));
    check_word("backpressure write count", 32, data_t'(mem_i.write_count));
  endtask

  task automatic test_control();
    addr_t jal_pc;
    prog.delete();
    prog.push_back(enc_i(F3_ADD, 1, 0, 5));
    prog.push_back(enc_i(F3_ADD, 2, 0, 5));
    prog.push_back(enc_b(F3_BEQ, 1, 2, 12)); // Taken, skips two stores.
    prog.push_back(enc_sw(1, 0, 12'h300));
    prog.push_back(enc_sw(1, 0, 12'h304));
    prog.push_back(enc_b(F3_BNE, 1, 2, 8));
    prog.push_back(enc_sw(2, 0, 12'h308));
    jal_pc = pc_at_reset + 4 * prog.size();
    prog.push_back(enc_jal(5, 12));
    prog.push_back(enc_sw(1, 0, 12'h30C));
    prog.push_back(enc_sw(1, 0, 12'h310));
    prog.push_back(enc_sw(5, 0, 12'h314));
    prog.push_back(WFI_INSN);
    run_program("control");
    check_mem("control beq", 32'h300, fill_value(32'h300 >> 2));
    check_mem("control beq", 32'h304, fill_value(32'h304 >> 2));
    check_mem("control bne", 32'h308, 5);
    check_mem("control jal", 32'h30C, fill_value(32'h30C >> 2));
    check_mem("control jal", 32'h310, fill_value(32'h310 >> 2));
    check_mem("control link", 32'h314, jal_pc + 4);
    check_word("control write count", 2, data_t'(mem_i.write_count));
  endtask

  task automatic test_halt();
    prog.delete();
    prog.push_back(enc_i(F3_ADD, 1, 0, 9));
    prog.push_back(enc_sw(1, 0, 12'h340));
    prog.push_back(WFI_INSN);
    prog.push_back(enc_sw(1, 0, 12'h344));
    prog.push_back(enc_i(F3_ADD, 1, 0, 1));
    prog.push_back(enc_sw(1, 0, 12'h340));
    run_program("wfi");
    repeat (5) @(negedge clk);
    check_flag("wfi halted stays", 1'b1, halted);
    check_flag("wfi fetch stopped", 1'b0, imem_valid);
    check_mem("wfi", 32'h340, 9);
    check_mem("wfi", 32'h344, fill_value(32'h344 >> 2));
    check_word("wfi write count", 1, data_t'(mem_i.write_count));

    prog.delete();
    prog.push_back(enc_i(F3_ADD, 1, 0, 11));
    prog.push_back(enc_sw(1, 0, 12'h348));
    prog.push_back(32'h0000_0000); // Illegal encoding.
    prog.push_back(enc_sw(1, 0, 12'h34C));
    run_program("illegal");
    check_mem("illegal", 32'h348, 11);
    check_mem("illegal", 32'h34C, fill_value(32'h34C >> 2));
    check_word("illegal write count", 1, data_t'(mem_i.write_count));
  endtask

  initial begin
    rst_n = 1'b0;
    prog.delete();
    load_memories();
    test_alu();
    test_hazards();
    test_backpressure();
    test_control();
    test_halt();
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tests/tb_mem_model.sv */
module tb_mem_model (
  input  logic          clk,
  input  logic          rst_n,
  input  rv_pkg::addr_t imem_addr,
  output rv_pkg::data_t imem_data,
  input  logic          dmem_valid,
  input  logic          dmem_we,
  input  rv_pkg::addr_t dmem_addr,
  input  rv_pkg::data_t dmem_wdata,
  output logic          dmem_ready,
  output rv_pkg::data_t dmem_rdata
);

  timeunit 1ns;
  timeprecision 1ps;

  import rv_pkg::*;

  data_t      imem [256];
  data_t      dmem [256];
  int         write_count;
  logic [7:0] lfsr = 8'd54;
  logic [1:0] delay;
  int         waited;
  logic       pending;

  // Galois form of x^8 + x^6 + x^5 + x^4 + 1.
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {1'b0, s[7:1]} ^ (s[0] ? 8'hB8 : 8'h00);
  endfunction

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]]; // Valid in the handshake cycle.

  initial dmem_ready = 1'b0;

  // Ready follows a request after 0 to 3 cycles.
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dmem_ready <= 1'b0;
      pending = 1'b0;
    end else if (!dmem_valid) begin
      dmem_ready <= 1'b0;
      pending = 1'b0;
    end else begin
      if (!pending || dmem_ready) begin // New request, the last one completed.
        delay[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        delay[1] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        waited = 0;
        pending = 1'b1;
      end else begin
        waited = waited + 1;
      end
      dmem_ready <= (waited >= int'(delay));
    end
  end

  always @(posedge clk) begin
    if (rst_n && dmem_valid && dmem_ready && dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
      write_count <= write_count + 1;
    end
  end

endmodule

/* source/riscv_core.sv */
module riscv_core #(
  parameter rv_pkg::addr_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst_n,
  output rv_pkg::addr_t imem_addr,
  output logic          imem_valid,
  input  rv_pkg::data_t imem_data,
  output logic          dmem_valid,
  output logic          dmem_we,
  output rv_pkg::addr_t dmem_addr,
  output rv_pkg::data_t dmem_wdata,
  input  logic          dmem_ready,
  input  rv_pkg::data_t dmem_rdata,
  output logic          halted
);

  import rv_pkg::*;

  logic    stall_pc, stall_if, flush_if, stall_id, bubble_id, stall_ex;
  logic    dep_found, mem_stall_req, br_taken, halt_req;
  addr_t   br_target;

  addr_t   if_pc;
  data_t   if_insn;

  reg_t    rs1, rs2;
  logic    rs1_used, rs2_used;
  data_t   rs1_data, rs2_data;

  addr_t   ex_pc;
  data_t   ex_a, ex_b, ex_store, ex_imm;
  reg_t    ex_rd;
  logic    ex_rd_we, ex_halt;
  alu_op_e ex_alu_op;
  mem_op_e ex_mem_op;
  branch_e ex_branch;

  data_t   mem_result, mem_store;
  reg_t    mem_rd;
  logic    mem_rd_we;
  mem_op_e mem_op;

  reg_t    wb_rd;
  logic    wb_we;
  data_t   wb_data;

  pipe_control ctrl_i (
    .clk(clk), .rst_n(rst_n),
    .dep_found(dep_found), .mem_stall_req(mem_stall_req),
    .br_taken(br_taken), .halt_req(halt_req),
    .stall_pc(stall_pc), .stall_if(stall_if), .flush_if(flush_if),
    .stall_id(stall_id), .bubble_id(bubble_id), .stall_ex(stall_ex),
    .halted(halted)
  );

  stage_if #(.reset_pc(reset_pc)) if_i (
    .clk(clk), .rst_n(rst_n),
    .stall_pc(stall_pc), .stall_if(stall_if), .flush_if(flush_if),
    .br_taken(br_taken), .halted(halted), .br_target(br_target),
    .imem_data(imem_data), .imem_addr(imem_addr), .imem_valid(imem_valid),
    .if_pc(if_pc), .if_insn(if_insn)
  );

  stage_id id_i (
    .clk(clk), .rst_n(rst_n),
    .stall_id(stall_id), .bubble_id(bubble_id),
    .if_pc(if_pc), .if_insn(if_insn),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1(rs1), .rs2(rs2), .rs1_used(rs1_used), .rs2_used(rs2_used),
    .ex_pc(ex_pc), .ex_a(ex_a), .ex_b(ex_b), .ex_store(ex_store),
    .ex_rd(ex_rd), .ex_rd_we(ex_rd_we), .ex_alu_op(ex_alu_op),
    .ex_mem_op(ex_mem_op), .ex_branch(ex_branch), .ex_imm(ex_imm),
    .ex_halt(ex_halt)
  );

  regfile rf_i (
    .clk(clk), .rst_n(rst_n),
    .wb_we(wb_we), .wb_rd(wb_rd), .rs1(rs1), .rs2(rs2), .wb_data(wb_data),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  dependency_unit dep_i (
    .rs1(rs1), .rs2(rs2), .ex_rd(ex_rd), .mem_rd(mem_rd),
    .rs1_used(rs1_used), .rs2_used(rs2_used),
    .ex_rd_we(ex_rd_we), .mem_rd_we(mem_rd_we),
    .dep_found(dep_found)
  );

  stage_ex ex_i (
    .clk(clk), .rst_n(rst_n), .stall_ex(stall_ex),
    .ex_pc(ex_pc), .ex_a(ex_a), .ex_b(ex_b), .ex_store(ex_store), .ex_imm(ex_imm),
    .ex_rd(ex_rd), .ex_rd_we(ex_rd_we), .ex_halt(ex_halt),
    .ex_alu_op(ex_alu_op), .ex_mem_op(ex_mem_op), .ex_branch(ex_branch),
    .br_taken(br_taken), .halt_req(halt_req), .br_target(br_target),
    .mem_result(mem_result), .mem_store(mem_store),
    .mem_rd(mem_rd), .mem_rd_we(mem_rd_we), .mem_op(mem_op)
  );

  stage_mem mem_i (
    .clk(clk), .rst_n(rst_n),
    .mem_result(mem_result), .mem_store(mem_store),
    .mem_rd(mem_rd), .mem_rd_we(mem_rd_we), .mem_op(mem_op),
    .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata),
    .dmem_valid(dmem_valid), .dmem_we(dmem_we),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .mem_stall_req(mem_stall_req),
    .wb_rd(wb_rd), .wb_we(wb_we), .wb_data(wb_data)
  );

endmodule

/* source/stage_mem.sv */
module stage_mem (
  input  logic            clk,
  input  logic            rst_n,
  input  rv_pkg::data_t   mem_result,
  input  rv_pkg::data_t   mem_store,
  input  rv_pkg::reg_t    mem_rd,
  input  logic            mem_rd_we,
  input  rv_pkg::mem_op_e mem_op,
  input  logic            dmem_ready,
  input  rv_pkg::data_t   dmem_rdata,
  output logic            dmem_valid,
  output logic            dmem_we,
  output rv_pkg::addr_t   dmem_addr,
  output rv_pkg::data_t   dmem_wdata,
  output logic            mem_stall_req,
  output rv_pkg::reg_t    wb_rd,
  output logic            wb_we,
  output rv_pkg::data_t   wb_data
);

  import rv_pkg::*;

  // EX/MEM holds while waiting, which keeps the request stable.
  assign dmem_valid    = (mem_op != MEM_NONE);
  assign dmem_we       = (mem_op == MEM_STORE);
  assign dmem_addr     = mem_result;
  assign dmem_wdata    = mem_store;
  assign mem_stall_req = dmem_valid & ~dmem_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we <= 1'b0;
    end else begin
      wb_we <= mem_rd_we & ~mem_stall_req; // Bubble while the bus waits.
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= mem_rd;
    wb_data <= (mem_op == MEM_LOAD) ? dmem_rdata : mem_result;
  end

endmodule

/* source/stage_ex.sv */
module stage_ex (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            stall_ex,
  input  rv_pkg::addr_t   ex_pc,
  input  rv_pkg::data_t   ex_a,
  input  rv_pkg::data_t   ex_b,
  input  rv_pkg::data_t   ex_store,
  input  rv_pkg::data_t   ex_imm,
  input  rv_pkg::reg_t    ex_rd,
  input  logic            ex_rd_we,
  input  logic            ex_halt,
  input  rv_pkg::alu_op_e ex_alu_op,
  input  rv_pkg::mem_op_e ex_mem_op,
  input  rv_pkg::branch_e ex_branch,
  output logic            br_taken,
  output logic            halt_req,
  output rv_pkg::addr_t   br_target,
  output rv_pkg::data_t   mem_result,
  output rv_pkg::data_t   mem_store,
  output rv_pkg::reg_t    mem_rd,
  output logic            mem_rd_we,
  output rv_pkg::mem_op_e mem_op
);

  import rv_pkg::*;

  data_t alu_out;
  data_t result;

  always_comb begin
    case (ex_alu_op)
      ALU_SUB:    alu_out = ex_a - ex_b;
      ALU_AND:    alu_out = ex_a & ex_b;
      ALU_OR:     alu_out = ex_a | ex_b;
      ALU_XOR:    alu_out = ex_a ^ ex_b;
      ALU_SLT:    alu_out = {31'b0, $signed(ex_a) < $signed(ex_b)};
      ALU_PASS_B: alu_out = ex_b;
      default:    alu_out = ex_a + ex_b;
    endcase
  end

  always_comb begin
    case (ex_branch)
      BR_BEQ:  br_taken = (ex_a == ex_b);
      BR_BNE:  br_taken = (ex_a != ex_b);
      BR_JUMP: br_taken = 1'b1;
      default: br_taken = 1'b0;
    endcase
  end

  assign br_target = ex_pc + ex_imm;
  assign result    = (ex_branch == BR_JUMP) ? ex_pc + 32'd4 : alu_out; // JAL link.
  assign halt_req  = ex_halt;

  // EX/MEM.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rd_we <= 1'b0;
      mem_op    <= MEM_NONE;
    end else if (!stall_ex) begin
      mem_rd_we <= ex_rd_we;
      mem_op    <= ex_mem_op;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_ex) begin
      mem_result <= result;
      mem_store  <= ex_store;
      mem_rd     <= ex_rd;
    end
  end

endmodule

/* source/dependency_unit.sv */
module dependency_unit (
  input  rv_pkg::reg_t rs1,
  input  rv_pkg::reg_t rs2,
  input  rv_pkg::reg_t ex_rd,
  input  rv_pkg::reg_t mem_rd,
  input  logic         rs1_used,
  input  logic         rs2_used,
  input  logic         ex_rd_we,
  input  logic         mem_rd_we,
  output logic         dep_found
);

  logic rs1_hit;
  logic rs2_hit;

  // Results still in EX or MEM are not yet visible in the register file.
  assign rs1_hit = rs1_used && (rs1 != 5'd0) &&
                   ((ex_rd_we && ex_rd == rs1) || (mem_rd_we && mem_rd == rs1));
  assign rs2_hit = rs2_used && (rs2 != 5'd0) &&
                   ((ex_rd_we && ex_rd == rs2) || (mem_rd_we && mem_rd == rs2));

  assign dep_found = rs1_hit | rs2_hit;

endmodule

/* source/regfile.sv */
module regfile (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          wb_we,
  input  rv_pkg::reg_t  wb_rd,
  input  rv_pkg::reg_t  rs1,
  input  rv_pkg::reg_t  rs2,
  input  rv_pkg::data_t wb_data,
  output rv_pkg::data_t rs1_data,
  output rv_pkg::data_t rs2_data
);

  import rv_pkg::*;

  data_t regs [32];
  logic  wr_en;

  assign wr_en = wb_we && (wb_rd != 5'd0); // x0 stays zero.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wr_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Write-through so decode sees the value retiring this cycle.
  assign rs1_data = (wr_en && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (wr_en && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

/* source/stage_id.sv */
module stage_id (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            stall_id,
  input  logic            bubble_id,
  input  rv_pkg::addr_t   if_pc,
  input  rv_pkg::data_t   if_insn,
  input  rv_pkg::data_t   rs1_data,
  input  rv_pkg::data_t   rs2_data,
  output rv_pkg::reg_t    rs1,
  output rv_pkg::reg_t    rs2,
  output logic            rs1_used,
  output logic            rs2_used,
  output rv_pkg::addr_t   ex_pc,
  output rv_pkg::data_t   ex_a,
  output rv_pkg::data_t   ex_b,
  output rv_pkg::data_t   ex_store,
  output rv_pkg::reg_t    ex_rd,
  output logic            ex_rd_we,
  output rv_pkg::alu_op_e ex_alu_op,
  output rv_pkg::mem_op_e ex_mem_op,
  output rv_pkg::branch_e ex_branch,
  output rv_pkg::data_t   ex_imm,
  output logic            ex_halt
);

  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  data_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  data_t      d_b, d_imm;
  logic       d_rd_we, d_halt;
  alu_op_e    d_alu_op;
  mem_op_e    d_mem_op;
  branch_e    d_branch;

  assign opcode = opcode_e'(if_insn[6:0]);
  assign funct3 = if_insn[14:12];
  assign funct7 = if_insn[31:25];
  assign rs1    = if_insn[19:15];
  assign rs2    = if_insn[24:20];

  assign imm_i = {{20{if_insn[31]}}, if_insn[31:20]};
  assign imm_s = {{20{if_insn[31]}}, if_insn[31:25], if_insn[11:7]};
  assign imm_b = {{19{if_insn[31]}}, if_insn[31], if_insn[7], if_insn[30:25],
                  if_insn[11:8], 1'b0};
  assign imm_u = {if_insn[31:12], 12'b0};
  assign imm_j = {{11{if_insn[31]}}, if_insn[31], if_insn[19:12], if_insn[20],
                  if_insn[30:21], 1'b0};

  always_comb begin
    d_alu_op = ALU_ADD;
    d_mem_op = MEM_NONE;
    d_branch = BR_NONE;
    d_rd_we  = 1'b0;
    d_halt   = 1'b0;
    d_b      = imm_i;
    d_imm    = imm_i;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    case (opcode)
      OPC_OP: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        d_rd_we  = 1'b1;
        d_b      = rs2_data;
        case (funct3)
          F3_ADD: d_alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_SLT: d_alu_op = ALU_SLT;
          F3_XOR: d_alu_op = ALU_XOR;
          F3_OR:  d_alu_op = ALU_OR;
          F3_AND: d_alu_op = ALU_AND;
          default: d_halt = 1'b1;
        endcase
        if (funct7 != F7_BASE && !(funct7 == F7_SUB && funct3 == F3_ADD)) d_halt = 1'b1;
      end
      OPC_OP_IMM: begin
        rs1_used = 1'b1;
        d_rd_we  = 1'b1;
        case (funct3)
          F3_ADD: d_alu_op = ALU_ADD;
          F3_SLT: d_alu_op = ALU_SLT;
          F3_XOR: d_alu_op = ALU_XOR;
          F3_OR:  d_alu_op = ALU_OR;
          F3_AND: d_alu_op = ALU_AND;
          default: d_halt = 1'b1; // Shifts are not supported.
        endcase
      end
      OPC_LUI: begin
        d_rd_we  = 1'b1;
        d_alu_op = ALU_PASS_B;
        d_b      = imm_u;
      end
      OPC_LOAD: begin
        rs1_used = 1'b1;
        d_rd_we  = 1'b1;
        d_mem_op = MEM_LOAD;
        d_halt   = (funct3 != F3_WORD);
      end
      OPC_STORE: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        d_mem_op = MEM_STORE;
        d_b      = imm_s;
        d_halt   = (funct3 != F3_WORD);
      end
      OPC_BRANCH: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        d_b      = rs2_data;
        d_imm    = imm_b;
        case (funct3)
          F3_BEQ: d_branch = BR_BEQ;
          F3_BNE: d_branch = BR_BNE;
          default: d_halt = 1'b1;
        endcase
      end
      OPC_JAL: begin
        d_rd_we  = 1'b1;
        d_branch = BR_JUMP;
        d_imm    = imm_j;
      end
      default: d_halt = 1'b1; // WFI, other SYSTEM encodings and anything unknown.
    endcase
    if (d_halt) begin
      d_rd_we  = 1'b0;
      d_mem_op = MEM_NONE;
      d_branch = BR_NONE;
    end
  end

  // ID/EX control.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_rd_we  <= 1'b0;
      ex_mem_op <= MEM_NONE;
      ex_branch <= BR_NONE;
      ex_halt   <= 1'b0;
    end else if (!stall_id) begin
      ex_rd_we  <= d_rd_we & ~bubble_id;
      ex_mem_op <= bubble_id ? MEM_NONE : d_mem_op;
      ex_branch <= bubble_id ? BR_NONE : d_branch;
      ex_halt   <= d_halt & ~bubble_id;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_id) begin
      ex_pc     <= if_pc;
      ex_a      <= rs1_data;
      ex_b      <= d_b;
      ex_store  <= rs2_data;
      ex_rd     <= if_insn[11:7];
      ex_alu_op <= d_alu_op;
      ex_imm    <= d_imm;
    end
  end

endmodule

/* source/stage_if.sv */
module stage_if #(
  parameter rv_pkg::addr_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          stall_pc,
  input  logic          stall_if,
  input  logic          flush_if,
  input  logic          br_taken,
  input  logic          halted,
  input  rv_pkg::addr_t br_target,
  input  rv_pkg::data_t imem_data,
  output rv_pkg::addr_t imem_addr,
  output logic          imem_valid,
  output rv_pkg::addr_t if_pc,
  output rv_pkg::data_t if_insn
);

  import rv_pkg::*;

  addr_t pc;
  addr_t pc_next;

  assign pc_next    = br_taken ? br_target : pc + 32'd4;
  assign imem_addr  = pc;
  assign imem_valid = ~halted;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (!stall_pc) begin
      pc <= pc_next;
    end
  end

  // IF/ID. A flush turns the slot into a NOP.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_insn <= NOP_INSN;
    end else if (flush_if) begin
      if_insn <= NOP_INSN;
    end else if (!stall_if) begin
      if_insn <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_if) if_pc <= pc;
  end

endmodule

/* source/pipe_control.sv */
module pipe_control (
  input  logic clk,
  input  logic rst_n,
  input  logic dep_found,
  input  logic mem_stall_req,
  input  logic br_taken,
  input  logic halt_req,
  output logic stall_pc,
  output logic stall_if,
  output logic flush_if,
  output logic stall_id,
  output logic bubble_id,
  output logic stall_ex,
  output logic halted
);

  logic stop;
  logic dep_hold;

  assign stop     = halt_req | halted;        // Fetch stops once a halt is seen.
  assign dep_hold = dep_found & ~br_taken;    // A redirect squashes the waiting instruction.

  // A memory wait freezes everything, so it wins over every other request.
  assign stall_pc  = mem_stall_req | stop | dep_hold;
  assign stall_if  = mem_stall_req | (dep_hold & ~stop);
  assign flush_if  = ~mem_stall_req & (br_taken | stop);
  assign stall_id  = mem_stall_req;
  assign bubble_id = ~mem_stall_req & (dep_found | br_taken | stop);
  assign stall_ex  = mem_stall_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (halt_req && !mem_stall_req) begin
      halted <= 1'b1; // Sticky until reset.
    end
  end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_t;

  // Major opcodes of the supported subset.
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_JUMP
  } branch_e;

  localparam data_t NOP_INSN = 32'h0000_0013; // addi x0, x0, 0
  localparam data_t WFI_INSN = 32'h1050_0073;

  // funct3 and funct7 fields.
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010; // LW and SW.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage
